// File: hdl/adc_gather_pkg.sv
`default_nettype none

package adc_gather_pkg;

	typedef logic [15:0]  adc_sample_t;
	// channel A in [31:16], channel B in [15:0]
	typedef logic [31:0]  sample_word_t;
	// word 0 in [31:0]
	typedef logic [127:0] beat_t;
	typedef logic [7:0]   wave_pos_t;
	typedef logic [4:0]   frame_id_t;
	typedef logic [31:0]  dma_addr_t;

	localparam logic [2:0] DDR_REGION     = 3'd3;
	localparam int         POS_SHIFT      = 21;
	localparam int         BEAT_BYTES     = 16;
	localparam int         WORDS_PER_BEAT = 4;

	typedef struct packed {
		logic        valid;
		logic        sop;
		logic        eop;
		adc_sample_t data;
	} adc_in_t;

	typedef struct packed {
		logic         en;
		sample_word_t data;
	} wr_req_t;

	// ----------------------------------------
	// dma command word, addr in [63:32]
	typedef struct packed {
		dma_addr_t   addr;
		frame_id_t   frame_id;
		logic [7:0]  burst_idx;
		logic [18:0] pad;
	} dma_cmd_t;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		DONE
	} rd_state_t;

endpackage

`default_nettype wire

// File: hdl/sample_packer.sv
`default_nettype none

module sample_packer import adc_gather_pkg::*; #(
	parameter int BANK_AW = 8
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire adc_in_t            cha,
	input  wire adc_in_t            chb,
	input  wire logic [1:0]         chirp_group,
	input  wire wave_pos_t          wave_position,
	output wr_req_t                 wr,
	output logic [BANK_AW-1:0]      wr_addr,
	output logic                    frame_start,
	output logic                    frame_end,
	output wave_pos_t               frame_pos
);

	adc_in_t            a_q;
	adc_sample_t        b_q;
	wave_pos_t          pos_q;
	wave_pos_t          start_pos;
	logic [1:0]         chirp_cnt;
	logic [1:0]         chirp_last;
	logic [BANK_AW-1:0] wr_cnt;
	logic [BANK_AW-1:0] next_addr;
	logic               first;
	logic               last;
	logic               wr_en_q;
	sample_word_t       wr_data_q;

	always_comb begin
		case (chirp_group)
			2'd0:    chirp_last = 2'd0;
			2'd1:    chirp_last = 2'd1;
			default: chirp_last = 2'd3;
		endcase
	end

	// first sop of a frame restarts the bank address
	assign first     = a_q.valid && a_q.sop && (chirp_cnt == 2'd0);
	assign last      = a_q.valid && a_q.eop && (chirp_cnt == chirp_last);
	assign next_addr = first ? '0 : wr_cnt;

	// ----------------------------------------
	// stage 1
	always_ff @(posedge clk) begin
		if (rst) begin
			a_q <= '0;
		end else begin
			a_q <= cha;
		end
	end

	always_ff @(posedge clk) begin
		b_q   <= chb.data;
		pos_q <= wave_position;
	end

	// ----------------------------------------
	// stage 2, write request and frame tracking
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en_q     <= 1'b0;
			frame_start <= 1'b0;
			frame_end   <= 1'b0;
			chirp_cnt   <= '0;
			wr_cnt      <= '0;
			start_pos   <= '0;
			frame_pos   <= '0;
		end else begin
			wr_en_q     <= a_q.valid;
			frame_start <= first;
			frame_end   <= last;
			if (a_q.valid) begin
				wr_cnt <= next_addr + 1'b1;
				if (a_q.eop)
					chirp_cnt <= last ? 2'd0 : chirp_cnt + 2'd1;
			end
			if (first)
				start_pos <= pos_q;
			// position of the last completed frame
			if (last)
				frame_pos <= first ? pos_q : start_pos;
		end
	end

	always_ff @(posedge clk) begin
		wr_data_q <= {a_q.data, b_q};
		wr_addr   <= next_addr;
	end

	assign wr = '{en: wr_en_q, data: wr_data_q};

endmodule

`default_nettype wire

// File: hdl/pingpong_buffer.sv
`default_nettype none

module pingpong_buffer import adc_gather_pkg::*; #(
	parameter int BANK_AW = 8
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire wr_req_t            wr,
	input  wire logic [BANK_AW-1:0] wr_addr,
	input  wire logic               frame_end,
	input  wire logic               rd_en,
	input  wire logic [BANK_AW-3:0] rd_addr,
	input  wire logic               bank_release,
	output beat_t                   rd_data,
	output logic                    bank_full,
	output logic                    overrun
);

	// each lane holds one word position of a beat, both banks
	localparam int LANE_DEPTH = 2 ** (BANK_AW - 1);

	logic         wr_bank;
	logic         rd_busy;
	logic         rd_free;
	sample_word_t rd_q [WORDS_PER_BEAT];

	genvar l;
	generate
		for (l = 0; l < WORDS_PER_BEAT; l++) begin : g_lane
			sample_word_t lane_mem [LANE_DEPTH];

			always_ff @(posedge clk) begin
				if (wr.en && (wr_addr[1:0] == l))
					lane_mem[{wr_bank, wr_addr[BANK_AW-1:2]}] <= wr.data;
				if (rd_en)
					rd_q[l] <= lane_mem[{~wr_bank, rd_addr}];
			end

			always_ff @(posedge clk) begin
				rd_data[l*32 +: 32] <= rd_q[l];
			end
		end
	endgenerate

	// ----------------------------------------
	// bank ownership
	assign rd_free = !rd_busy || bank_release;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_bank   <= 1'b0;
			rd_busy   <= 1'b0;
			bank_full <= 1'b0;
			overrun   <= 1'b0;
		end else begin
			bank_full <= frame_end && rd_free;
			if (frame_end && rd_free) begin
				wr_bank <= ~wr_bank;
				rd_busy <= 1'b1;
			end else if (bank_release) begin
				rd_busy <= 1'b0;
			end
			// frame dropped, write bank gets reused
			if (frame_end && !rd_free)
				overrun <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/burst_reader.sv
`default_nettype none

module burst_reader import adc_gather_pkg::*; #(
	parameter int BANK_AW = 8
) (
	input  wire logic         clk,
	input  wire logic         rst,
	input  wire logic         bank_full,
	input  wire beat_t        rd_data,
	input  wire logic         cmd_hold,
	input  wire logic         out_ready,
	output logic              rd_en,
	output logic [BANK_AW-3:0] rd_addr,
	output logic              bank_release,
	output beat_t             out_data,
	output logic              out_valid
);

	localparam int BEATS = 2 ** (BANK_AW - 2);
	localparam int QDEPTH = 4;

	rd_state_t        state;
	logic [BANK_AW-3:0] addr;
	logic [2:0]       used;
	logic [1:0]       rd_pipe;
	beat_t            q_mem [QDEPTH];
	logic [1:0]       wptr;
	logic [1:0]       rptr;
	logic [2:0]       q_cnt;
	logic             launch;
	logic             push;
	logic             pop;

	// in-flight reads plus queued beats never exceed the queue
	assign launch = (state == READ) && !cmd_hold && (used < QDEPTH);
	assign push   = rd_pipe[1];
	assign pop    = out_valid && out_ready;

	assign rd_en        = launch;
	assign rd_addr      = addr;
	assign out_valid    = (q_cnt != 3'd0) && !cmd_hold;
	assign out_data     = q_mem[rptr];
	assign bank_release = (state == DONE) && pop && (used == 3'd1);

	// ----------------------------------------
	// address walk
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			addr  <= '0;
		end else begin
			case (state)
				IDLE: begin
					addr <= '0;
					if (bank_full)
						state <= READ;
				end
				READ: begin
					if (launch) begin
						addr <= addr + 1'b1;
						if (addr == BEATS - 1)
							state <= DONE;
					end
				end
				DONE: begin
					if (bank_release)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// credits and prefetch queue
	always_ff @(posedge clk) begin
		if (rst) begin
			used    <= '0;
			rd_pipe <= '0;
			wptr    <= '0;
			rptr    <= '0;
			q_cnt   <= '0;
		end else begin
			used    <= used + {2'd0, launch} - {2'd0, pop};
			rd_pipe <= {rd_pipe[0], launch};
			q_cnt   <= q_cnt + {2'd0, push} - {2'd0, pop};
			if (push)
				wptr <= wptr + 2'd1;
			if (pop)
				rptr <= rptr + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			q_mem[wptr] <= rd_data;
	end

endmodule

`default_nettype wire

// File: hdl/dma_cmd_gen.sv
`default_nettype none

module dma_cmd_gen import adc_gather_pkg::*; #(
	parameter int BANK_AW     = 8,
	parameter int BURST_BEATS = 16
) (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      frame_start,
	input  wire wave_pos_t frame_pos,
	input  wire logic      out_valid,
	input  wire logic      out_ready,
	input  wire logic      cmd_ready,
	output dma_cmd_t       cmd,
	output logic           cmd_valid,
	output logic           cmd_hold,
	output logic           frame_done
);

	localparam int BEATS  = 2 ** (BANK_AW - 2);
	localparam int BURSTS = BEATS / BURST_BEATS;
	localparam int BW     = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
	localparam dma_addr_t BURST_BYTES = dma_addr_t'(BURST_BEATS * BEAT_BYTES);

	logic [BW-1:0] beat_cnt;
	logic [7:0]    burst_cnt;
	frame_id_t     frame_id;
	wave_pos_t     rd_pos;
	wave_pos_t     cur_pos;
	logic          armed;
	logic          captured;
	logic          last_burst;
	logic          xfer;
	logic          accept;
	dma_addr_t     addr;

	assign xfer     = out_valid && out_ready;
	assign accept   = cmd_valid && cmd_ready;
	assign cmd_hold = cmd_valid;
	// position is taken when the frame's first beat shows up
	assign cur_pos  = captured ? rd_pos : frame_pos;
	assign addr     = (dma_addr_t'(DDR_REGION) << (POS_SHIFT + 8))
	                | (dma_addr_t'(cur_pos) << POS_SHIFT)
	                | (dma_addr_t'(burst_cnt) * BURST_BYTES);

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt   <= '0;
			burst_cnt  <= '0;
			frame_id   <= '0;
			armed      <= 1'b0;
			captured   <= 1'b0;
			last_burst <= 1'b0;
			cmd_valid  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= accept && last_burst;
			if (frame_start)
				armed <= 1'b1;
			if (out_valid && armed && !captured)
				captured <= 1'b1;
			if (xfer) begin
				beat_cnt <= (beat_cnt == BURST_BEATS - 1) ? '0 : beat_cnt + 1'b1;
				if (beat_cnt == BURST_BEATS - 1) begin
					cmd_valid  <= 1'b1;
					last_burst <= (burst_cnt == BURSTS - 1);
					burst_cnt  <= (burst_cnt == BURSTS - 1) ? 8'd0 : burst_cnt + 8'd1;
				end
			end
			if (accept) begin
				cmd_valid <= 1'b0;
				if (last_burst) begin
					frame_id <= frame_id + 1'b1;
					captured <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_valid && !captured)
			rd_pos <= frame_pos;
		if (xfer && (beat_cnt == BURST_BEATS - 1))
			cmd <= '{addr: addr, frame_id: frame_id, burst_idx: burst_cnt, pad: '0};
	end

endmodule

`default_nettype wire

// File: hdl/adc_gather_top.sv
`default_nettype none

module adc_gather_top import adc_gather_pkg::*; #(
	parameter int BANK_AW     = 8,
	parameter int BURST_BEATS = 16
) (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire adc_in_t    cha,
	input  wire adc_in_t    chb,
	input  wire logic [1:0] chirp_group,
	input  wire wave_pos_t  wave_position,
	output beat_t           out_data,
	output logic            out_valid,
	input  wire logic       out_ready,
	output dma_cmd_t        cmd,
	output logic            cmd_valid,
	input  wire logic       cmd_ready,
	output logic            frame_done,
	output logic            overrun
);

	wr_req_t            wr;
	logic [BANK_AW-1:0] wr_addr;
	logic               frame_start;
	logic               frame_end;
	wave_pos_t          frame_pos;
	logic               bank_full;
	logic               bank_release;
	logic               rd_en;
	logic [BANK_AW-3:0] rd_addr;
	beat_t              rd_data;
	logic               cmd_hold;

	// ----------------------------------------
	// write side
	sample_packer #(
		.BANK_AW (BANK_AW)
	) i_sample_packer (
		.clk           (clk),
		.rst           (rst),
		.cha           (cha),
		.chb           (chb),
		.chirp_group   (chirp_group),
		.wave_position (wave_position),
		.wr            (wr),
		.wr_addr       (wr_addr),
		.frame_start   (frame_start),
		.frame_end     (frame_end),
		.frame_pos     (frame_pos)
	);

	pingpong_buffer #(
		.BANK_AW (BANK_AW)
	) i_pingpong_buffer (
		.clk          (clk),
		.rst          (rst),
		.wr           (wr),
		.wr_addr      (wr_addr),
		.frame_end    (frame_end),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.bank_release (bank_release),
		.rd_data      (rd_data),
		.bank_full    (bank_full),
		.overrun      (overrun)
	);

	// ----------------------------------------
	// read side
	burst_reader #(
		.BANK_AW (BANK_AW)
	) i_burst_reader (
		.clk          (clk),
		.rst          (rst),
		.bank_full    (bank_full),
		.rd_data      (rd_data),
		.cmd_hold     (cmd_hold),
		.out_ready    (out_ready),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.bank_release (bank_release),
		.out_data     (out_data),
		.out_valid    (out_valid)
	);

	dma_cmd_gen #(
		.BANK_AW     (BANK_AW),
		.BURST_BEATS (BURST_BEATS)
	) i_dma_cmd_gen (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.frame_pos   (frame_pos),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.cmd_ready   (cmd_ready),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.cmd_hold    (cmd_hold),
		.frame_done  (frame_done)
	);

endmodule

`default_nettype wire

// File: tb/adc_gather_chk.sv
`default_nettype none

module adc_gather_chk import adc_gather_pkg::*; (
	input wire logic     clk,
	input wire logic     rst,
	input wire beat_t    out_data,
	input wire logic     out_valid,
	input wire logic     out_ready,
	input wire dma_cmd_t cmd,
	input wire logic     cmd_valid,
	input wire logic     cmd_ready,
	input wire logic     frame_done,
	input wire logic     overrun
);

	timeunit 1ns;
	timeprecision 1ps;

	int fails = 0;

	// payloads held until taken
	a_beat_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else begin
			fails++;
			$error("out_valid or out_data changed before the transfer");
		end

	a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
		else begin
			fails++;
			$error("cmd_valid or cmd changed before the transfer");
		end

	a_no_beat_in_hold: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> !(out_valid && out_ready))
		else begin
			fails++;
			$error("beat transferred while a command was pending");
		end

	// frame done follows an accepted command
	a_done_after_cmd: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> $past(cmd_valid && cmd_ready))
		else begin
			fails++;
			$error("frame_done without a command accepted the cycle before");
		end

	a_overrun_sticky: assert property (@(posedge clk) disable iff (rst)
		overrun |=> overrun)
		else begin
			fails++;
			$error("overrun cleared without reset");
		end

endmodule

`default_nettype wire

// File: tb/tb_adc_gather.sv
`default_nettype none

module tb_adc_gather import adc_gather_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BANK_WORDS   = 256;
	localparam int BEATS        = BANK_WORDS / 4;
	localparam int BURST_LEN    = 16;
	localparam int BURSTS       = BEATS / BURST_LEN;
	localparam int FRAMES       = 9;
	// clock cycles allowed per frame, fill plus drain
	localparam int FRAME_CYCLES = 3000;

	logic       clk = 1'b0;
	logic       rst;
	adc_in_t    cha;
	adc_in_t    chb;
	logic [1:0] chirp_group;
	wave_pos_t  wave_position;
	beat_t      out_data;
	logic       out_valid;
	logic       out_ready;
	dma_cmd_t   cmd;
	logic       cmd_valid;
	logic       cmd_ready;
	logic       frame_done;
	logic       overrun;

	integer    seed         = 54;
	int        beat_errors  = 0;
	int        cmd_errors   = 0;
	int        proto_errors = 0;
	int        kept         = 0;
	int        done_count   = 0;
	bit        stall        = 1'b0;
	bit        started      = 1'b0;
	bit        overrun_ok   = 1'b0;
	bit        overrun_q    = 1'b0;
	bit        done_due     = 1'b0;
	frame_id_t next_id      = '0;
	beat_t     exp_beats [$];
	dma_cmd_t  exp_cmds [$];

	always #10 clk = ~clk;

	adc_gather_top i_adc_gather_top (
		.clk           (clk),
		.rst           (rst),
		.cha           (cha),
		.chb           (chb),
		.chirp_group   (chirp_group),
		.wave_position (wave_position),
		.out_data      (out_data),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.cmd           (cmd),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.frame_done    (frame_done),
		.overrun       (overrun)
	);

	bind adc_gather_top adc_gather_chk i_adc_gather_chk (
		.clk        (clk),
		.rst        (rst),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.frame_done (frame_done),
		.overrun    (overrun)
	);

	// ----------------------------------------
	// one clock, fresh ready values, idle adc inputs
	task automatic next_cycle();
		@(posedge clk);
		#2;
		out_ready     = stall ? 1'b0 : (($random(seed) & 3) != 0);
		cmd_ready     = 1'($random(seed));
		wave_position = 8'($random(seed));
		cha = '{valid: 1'b0, sop: 1'($random(seed)), eop: 1'($random(seed)),
			data: 16'($random(seed))};
		chb = '{valid: 1'($random(seed)), sop: 1'b0, eop: 1'b0, data: 16'($random(seed))};
	endtask

	task automatic drive_frame(input logic [1:0] group, input bit keep);
		int           chirps;
		int           per_chirp;
		int           n;
		wave_pos_t    pos;
		sample_word_t words [BANK_WORDS];
		dma_cmd_t     exp_cmd;

		// let the previous frame's last sample clear the packer first
		repeat (2) next_cycle();
		chirp_group = group;
		chirps      = 1 << group;
		per_chirp   = BANK_WORDS / chirps;
		n           = 0;
		for (int c = 0; c < chirps; c++) begin
			for (int s = 0; s < per_chirp; s++) begin
				next_cycle();
				while (($random(seed) & 3) == 0)
					next_cycle();
				cha.valid = 1'b1;
				cha.sop   = (s == 0);
				cha.eop   = (s == per_chirp - 1);
				if (c == 0 && s == 0)
					pos = wave_position;
				words[n] = {cha.data, chb.data};
				n++;
			end
		end
		next_cycle();
		started = 1'b1;
		if (keep) begin
			for (int b = 0; b < BEATS; b++)
				exp_beats.push_back({words[4*b+3], words[4*b+2], words[4*b+1], words[4*b]});
			for (int k = 0; k < BURSTS; k++) begin
				exp_cmd = {(32'd3 << 29) | (32'(pos) << 21) | 32'(k * BURST_LEN * 16),
					next_id, 8'(k), 19'd0};
				exp_cmds.push_back(exp_cmd);
			end
			next_id++;
			kept++;
		end
	endtask

	task automatic drain();
		while (exp_beats.size() != 0 || exp_cmds.size() != 0 || done_count != kept)
			next_cycle();
	endtask

	// ----------------------------------------
	// output monitor, half a cycle after the edge
	always @(negedge clk) begin
		if (!rst) begin
			if (!started && (out_valid || cmd_valid || frame_done || overrun)) begin
				$display("output active before the first frame was complete");
				proto_errors++;
			end
			if (overrun && !overrun_q && !overrun_ok) begin
				$display("overrun set although the reader kept up");
				proto_errors++;
			end
			overrun_q = overrun;
			if (frame_done !== done_due) begin
				$display("** Error: frame_done = %h, expected %h", frame_done, done_due);
				proto_errors++;
			end
			if (frame_done)
				done_count++;
			done_due = 1'b0;
			if (out_valid && out_ready) begin
				if (cmd_valid) begin
					$display("beat transferred while a command was pending");
					proto_errors++;
				end
				if (exp_beats.size() == 0) begin
					$display("beat transferred with none expected");
					beat_errors++;
				end else begin
					if (out_data !== exp_beats[0]) begin
						$display("** Error: out_data = %h, expected %h", out_data, exp_beats[0]);
						beat_errors++;
					end
					void'(exp_beats.pop_front());
				end
			end
			if (cmd_valid && cmd_ready) begin
				if (exp_cmds.size() == 0) begin
					$display("command accepted with none expected");
					cmd_errors++;
				end else begin
					if (cmd !== exp_cmds[0]) begin
						$display("** Error: cmd = %h, expected %h", cmd, exp_cmds[0]);
						cmd_errors++;
					end
					done_due = (exp_cmds[0].burst_idx == BURSTS - 1);
					void'(exp_cmds.pop_front());
				end
			end
		end
	end

	initial begin
		#(FRAMES * FRAME_CYCLES * 20 + 16 * 20);
		$display("watchdog expired before all frames were read out");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		cha           = '0;
		chb           = '0;
		chirp_group   = '0;
		wave_position = '0;
		out_ready     = 1'b0;
		cmd_ready     = 1'b0;
		rst           = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		// two frames per chirp grouping
		for (int g = 0; g < 3; g++) begin
			drive_frame(2'(g), 1'b1);
			drive_frame(2'(g), 1'b1);
		end
		drain();

		// reader stalled across two frame ends, second frame dropped
		stall      = 1'b1;
		overrun_ok = 1'b1;
		drive_frame(2'd1, 1'b1);
		drive_frame(2'd2, 1'b0);
		repeat (4) next_cycle();
		stall = 1'b0;
		drive_frame(2'd0, 1'b1);
		drain();
		repeat (8) next_cycle();
		if (overrun !== 1'b1) begin
			$display("** Error: overrun = %h, expected 1", overrun);
			proto_errors++;
		end

		$display("errors: beat %0d, command %0d, protocol %0d, assertion %0d",
			beat_errors, cmd_errors, proto_errors, i_adc_gather_top.i_adc_gather_chk.fails);
		if (beat_errors + cmd_errors + proto_errors + i_adc_gather_top.i_adc_gather_chk.fails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: adc_gather_top.f
hdl/adc_gather_pkg.sv
hdl/sample_packer.sv
hdl/pingpong_buffer.sv
hdl/burst_reader.sv
hdl/dma_cmd_gen.sv
hdl/adc_gather_top.sv
tb/adc_gather_chk.sv
tb/tb_adc_gather.sv

// File: Makefile
TOP := tb_adc_gather

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f adc_gather_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f adc_gather_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
